// File: hdl/conv_quad_pkg.sv
`default_nettype none

package conv_quad_pkg;

    ////////////////////////////////////////
    // Data widths
    ////////////////////////////////////////

    // Signed input pixel
    typedef logic signed [7:0] pixel_t;

    // Signed kernel weight
    typedef logic signed [7:0] weight_t;

    // Nine 8x8 products fit without overflow
    typedef logic signed [19:0] acc_t;

    ////////////////////////////////////////
    // Job counts
    ////////////////////////////////////////

    // Tap count or tap index, 0 to 15
    typedef logic [3:0] tap_idx_t;

    // Outputs per job
    typedef logic [7:0] out_cnt_t;

    ////////////////////////////////////////
    // Defaults
    ////////////////////////////////////////

    // 3x3 kernel
    localparam int MAX_TAPS_DEFAULT = 9;

    // Prefetch entries
    localparam int BUF_DEPTH_DEFAULT = 16;

endpackage

`default_nettype wire

// File: hdl/pixel_buf_if.sv
`timescale 1ns/1ns
`default_nettype none

interface pixel_buf_if
    import conv_quad_pkg::*;
();

    // Write side, one strobe per pixel
    logic   push;
    pixel_t push_data;

    // Read side, head entry always visible
    logic   pop;
    pixel_t pop_data;
    logic   not_empty;

    modport loader (
        output push,
        output push_data
    );

    modport buffer (
        input  push,
        input  push_data,
        input  pop,
        output pop_data,
        output not_empty
    );

    modport engine (
        output pop,
        input  pop_data,
        input  not_empty
    );

endinterface

`default_nettype wire

// File: hdl/pixel_loader.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_loader
    import conv_quad_pkg::*;
#(
    parameter int MAX_TAPS = MAX_TAPS_DEFAULT
) (
    input  wire logic     clk_core,
    input  wire logic     rst,
    input  wire logic     job_start,
    input  wire tap_idx_t job_num_taps,
    input  wire out_cnt_t job_num_outputs,
    input  wire logic     job_relu,
    input  wire logic     job_complete_ack,
    input  wire logic     pixel_valid,
    input  wire pixel_t   pixel_data,
    input  wire logic     job_done,
    output logic          job_accept,
    output logic          job_complete,
    output logic          job_go,
    output tap_idx_t      num_taps,
    output out_cnt_t      num_outputs,
    pixel_buf_if.loader   buf_port
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACTIVE,
        ST_COMPLETE
    } state_t;

    state_t      state;
    logic        relu_en;
    logic [11:0] pix_cnt;
    logic [11:0] quota;
    logic        take_job;
    pixel_t      act_pixel;

    assign take_job = (state == ST_IDLE) && job_start;

    // Engine is armed by the same strobe that accepts the job
    assign job_go = job_accept;

    ////////////////////////////////////////
    // Job control FSM
    ////////////////////////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            state        <= ST_IDLE;
            job_accept   <= 1'b0;
            job_complete <= 1'b0;
            pix_cnt      <= '0;
        end else begin
            job_accept <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        state      <= ST_ACTIVE;
                        job_accept <= 1'b1;
                        pix_cnt    <= '0;
                    end
                end
                ST_ACTIVE: begin
                    if (buf_port.push) begin
                        pix_cnt <= pix_cnt + 12'd1;
                    end
                    // Final result seen, complete goes up next cycle
                    if (job_done) begin
                        state        <= ST_COMPLETE;
                        job_complete <= 1'b1;
                    end
                end
                ST_COMPLETE: begin
                    if (job_complete_ack) begin
                        state        <= ST_IDLE;
                        job_complete <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Job parameters, held until the next acceptance
    always_ff @(posedge clk_core) begin
        if (take_job) begin
            num_taps    <= job_num_taps;
            num_outputs <= job_num_outputs;
            relu_en     <= job_relu;
        end
    end

    ////////////////////////////////////////
    // Activation and buffer writes
    ////////////////////////////////////////

    assign quota = {8'd0, num_taps} * {4'd0, num_outputs};

    // ReLU ahead of the multiplier
    assign act_pixel = (relu_en && pixel_data[7]) ? pixel_t'(0) : pixel_data;

    // Pixels past the quota are dropped
    assign buf_port.push      = (state == ST_ACTIVE) && pixel_valid && (pix_cnt < quota);
    assign buf_port.push_data = act_pixel;

    a_taps_in_range: assert property (
        @(posedge clk_core) disable iff (rst)
        job_accept |-> (num_taps >= tap_idx_t'(1)) && (int'(num_taps) <= MAX_TAPS)
    );

endmodule

`default_nettype wire

// File: hdl/prefetch_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module prefetch_buffer
    import conv_quad_pkg::*;
#(
    parameter int BUF_DEPTH = BUF_DEPTH_DEFAULT
) (
    input  wire logic   clk_core,
    input  wire logic   rst,
    pixel_buf_if.buffer buf_port
);

    localparam int AW = $clog2(BUF_DEPTH);

    pixel_t        mem [BUF_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;

    assign full = (count == (AW + 1)'(BUF_DEPTH));

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (buf_port.push) begin
                // Wrap for depths that are not a power of two
                if (wr_ptr == AW'(BUF_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + AW'(1);
                end
            end
            if (buf_port.pop) begin
                if (rd_ptr == AW'(BUF_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + AW'(1);
                end
            end
            // Push and pop together leave the count alone
            if (buf_port.push && !buf_port.pop) begin
                count <= count + (AW + 1)'(1);
            end else if (!buf_port.push && buf_port.pop) begin
                count <= count - (AW + 1)'(1);
            end
        end
    end

    // Storage
    always_ff @(posedge clk_core) begin
        if (buf_port.push) begin
            mem[wr_ptr] <= buf_port.push_data;
        end
    end

    assign buf_port.pop_data  = mem[rd_ptr];
    assign buf_port.not_empty = (count != '0);

    // A pop in the same cycle frees the slot being written
    a_no_overflow: assert property (
        @(posedge clk_core) disable iff (rst)
        buf_port.push |-> !full || buf_port.pop
    );

endmodule

`default_nettype wire

// File: hdl/weight_table.sv
`timescale 1ns/1ns
`default_nettype none

module weight_table
    import conv_quad_pkg::*;
#(
    parameter int MAX_TAPS = MAX_TAPS_DEFAULT
) (
    input  wire logic     clk_core,
    input  wire logic     rst,
    input  wire logic     weight_valid,
    input  wire weight_t  weight_data,
    input  wire logic     clear,
    input  wire tap_idx_t tap,
    output weight_t       weight
);

    weight_t  regs [MAX_TAPS];
    tap_idx_t wr_ptr;
    logic     wr_en;

    assign wr_en = weight_valid && (int'(wr_ptr) < MAX_TAPS);

    ////////////////////////////////////////
    // Sequential kernel load
    ////////////////////////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
        end else if (weight_valid) begin
            wr_ptr <= wr_ptr + 4'd1;
        end
    end

    always_ff @(posedge clk_core) begin
        if (wr_en) begin
            regs[wr_ptr] <= weight_data;
        end
    end

    // Unused tap slots read as zero
    assign weight = (int'(tap) < MAX_TAPS) ? regs[tap] : weight_t'(0);

    // Kernel load must fit in the table before the job runs
    a_no_table_overrun: assert property (
        @(posedge clk_core) disable iff (rst)
        weight_valid |-> int'(wr_ptr) < MAX_TAPS
    );

endmodule

`default_nettype wire

// File: hdl/mac_engine.sv
`timescale 1ns/1ns
`default_nettype none

module mac_engine
    import conv_quad_pkg::*;
#(
    parameter int MAX_TAPS = MAX_TAPS_DEFAULT
) (
    input  wire logic     clk_core,
    input  wire logic     rst,
    input  wire logic     job_go,
    input  wire tap_idx_t num_taps,
    input  wire out_cnt_t num_outputs,
    input  wire logic     weight_valid,
    input  wire weight_t  weight_data,
    pixel_buf_if.engine   buf_port,
    output logic          result_valid,
    output acc_t          result_data,
    output logic          job_done
);

    logic                running;
    logic                res_cyc;
    tap_idx_t            tap_cnt;
    out_cnt_t            out_cnt;
    acc_t                acc;
    weight_t             weight;
    logic signed [15:0]  product;
    logic                last_tap;
    logic                last_out;

    weight_table #(
        .MAX_TAPS (MAX_TAPS)
    ) i_weight_table (
        .clk_core     (clk_core),
        .rst          (rst),
        .weight_valid (weight_valid),
        .weight_data  (weight_data),
        .clear        (job_done),
        .tap          (tap_cnt),
        .weight       (weight)
    );

    // No pop while the result cycle is spent
    assign buf_port.pop = running && !res_cyc && buf_port.not_empty;

    assign product  = 16'(buf_port.pop_data) * 16'(weight);
    assign last_tap = (tap_cnt == num_taps - 4'd1);
    assign last_out = (out_cnt == num_outputs - 8'd1);

    ////////////////////////////////////////
    // Tap and output sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            running <= 1'b0;
            res_cyc <= 1'b0;
            tap_cnt <= '0;
            out_cnt <= '0;
        end else if (job_go) begin
            running <= 1'b1;
            res_cyc <= 1'b0;
            tap_cnt <= '0;
            out_cnt <= '0;
        end else if (res_cyc) begin
            res_cyc <= 1'b0;
            out_cnt <= out_cnt + 8'd1;
            if (last_out) begin
                running <= 1'b0;
            end
        end else if (buf_port.pop) begin
            if (last_tap) begin
                tap_cnt <= '0;
                res_cyc <= 1'b1;
            end else begin
                tap_cnt <= tap_cnt + 4'd1;
            end
        end
    end

    // Accumulator restarts after each result
    always_ff @(posedge clk_core) begin
        if (job_go || res_cyc) begin
            acc <= '0;
        end else if (buf_port.pop) begin
            acc <= acc + acc_t'(product);
        end
    end

    assign result_valid = res_cyc;
    assign result_data  = acc;
    assign job_done     = res_cyc && last_out;

    // Kernel reload only between jobs
    a_no_weight_while_armed: assert property (
        @(posedge clk_core) disable iff (rst)
        weight_valid |-> !running
    );

endmodule

`default_nettype wire

// File: hdl/conv_quad_top.sv
`timescale 1ns/1ns
`default_nettype none

module conv_quad_top
    import conv_quad_pkg::*;
#(
    parameter int MAX_TAPS  = MAX_TAPS_DEFAULT,
    parameter int BUF_DEPTH = BUF_DEPTH_DEFAULT
) (
    input  wire logic     clk_core,
    input  wire logic     rst,
    input  wire logic     job_start,
    input  wire tap_idx_t job_num_taps,
    input  wire out_cnt_t job_num_outputs,
    input  wire logic     job_relu,
    output logic          job_accept,
    output logic          job_complete,
    input  wire logic     job_complete_ack,
    input  wire logic     weight_valid,
    input  wire weight_t  weight_data,
    input  wire logic     pixel_valid,
    input  wire pixel_t   pixel_data,
    output logic          result_valid,
    output acc_t          result_data
);

    logic     job_go;
    logic     job_done;
    tap_idx_t num_taps;
    out_cnt_t num_outputs;

    pixel_buf_if i_buf_if ();

    ////////////////////////////////////////
    // Job control and activation
    ////////////////////////////////////////

    pixel_loader #(
        .MAX_TAPS (MAX_TAPS)
    ) i_pixel_loader (
        .clk_core         (clk_core),
        .rst              (rst),
        .job_start        (job_start),
        .job_num_taps     (job_num_taps),
        .job_num_outputs  (job_num_outputs),
        .job_relu         (job_relu),
        .job_complete_ack (job_complete_ack),
        .pixel_valid      (pixel_valid),
        .pixel_data       (pixel_data),
        .job_done         (job_done),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .job_go           (job_go),
        .num_taps         (num_taps),
        .num_outputs      (num_outputs),
        .buf_port         (i_buf_if.loader)
    );

    prefetch_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) i_prefetch_buffer (
        .clk_core (clk_core),
        .rst      (rst),
        .buf_port (i_buf_if.buffer)
    );

    ////////////////////////////////////////
    // Multiply and accumulate
    ////////////////////////////////////////

    mac_engine #(
        .MAX_TAPS (MAX_TAPS)
    ) i_mac_engine (
        .clk_core     (clk_core),
        .rst          (rst),
        .job_go       (job_go),
        .num_taps     (num_taps),
        .num_outputs  (num_outputs),
        .weight_valid (weight_valid),
        .weight_data  (weight_data),
        .buf_port     (i_buf_if.engine),
        .result_valid (result_valid),
        .result_data  (result_data),
        .job_done     (job_done)
    );

endmodule

`default_nettype wire

// File: tb/conv_quad_tb.sv
`timescale 1ns/1ns
`default_nettype none

module conv_quad_tb
    import conv_quad_pkg::*;
();

    localparam int MAX_TAPS  = MAX_TAPS_DEFAULT;
    localparam int BUF_DEPTH = BUF_DEPTH_DEFAULT;
    localparam int NUM_JOBS  = 6;

    typedef struct {
        int taps;
        int outs;
        bit relu;
        int gap_mode;
        int n_exp;
    } job_row_t;

    logic     clk_core = 1'b0;
    logic     rst;
    logic     job_start;
    tap_idx_t job_num_taps;
    out_cnt_t job_num_outputs;
    logic     job_relu;
    logic     job_accept;
    logic     job_complete;
    logic     job_complete_ack;
    logic     weight_valid;
    weight_t  weight_data;
    logic     pixel_valid;
    pixel_t   pixel_data;
    logic     result_valid;
    acc_t     result_data;

    job_row_t    jobs [NUM_JOBS];
    int          value_errs = 0;
    int          proto_errs = 0;
    int          res_seen;
    logic [15:0] lfsr_state;
    int          pix_vals [$];
    int          exp_vals [$];
    int          wgt_vals [MAX_TAPS];

    conv_quad_top #(
        .MAX_TAPS  (MAX_TAPS),
        .BUF_DEPTH (BUF_DEPTH)
    ) i_dut (
        .clk_core         (clk_core),
        .rst              (rst),
        .job_start        (job_start),
        .job_num_taps     (job_num_taps),
        .job_num_outputs  (job_num_outputs),
        .job_relu         (job_relu),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .job_complete_ack (job_complete_ack),
        .weight_valid     (weight_valid),
        .weight_data      (weight_data),
        .pixel_valid      (pixel_valid),
        .pixel_data       (pixel_data),
        .result_valid     (result_valid),
        .result_data      (result_data)
    );

    always #10 clk_core = ~clk_core;

    ////////////////////////////////////////
    // Random data and reference model
    ////////////////////////////////////////

    // Fibonacci LFSR with taps at bits 16, 14, 13 and 11
    function automatic int take_bits(int n);
        int   val;
        logic fb;
        val = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            val = (val << 1) | int'(fb);
        end
        return val;
    endfunction

    // Signed byte from -128 to 127
    function automatic int rand_byte();
        int v;
        v = take_bits(8);
        if (v > 127) begin
            v = v - 256;
        end
        return v;
    endfunction

    // Tap t of output idx uses pixel idx*taps+t and weight t
    function automatic int ref_output(int taps, int idx, bit relu);
        int sum;
        int p;
        sum = 0;
        for (int t = 0; t < taps; t++) begin
            p = pix_vals[idx * taps + t];
            if (relu && p < 0) begin
                p = 0;
            end
            sum = sum + p * wgt_vals[t];
        end
        return sum;
    endfunction

    task automatic check_value(int got, int exp, string what);
        assert (got == exp) else begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_protocol(bit cond, string what);
        assert (cond) else begin
            $display("** Error at %0t ns: %s", $time, what);
            proto_errs++;
        end
    endtask

    ////////////////////////////////////////
    // Job phases
    ////////////////////////////////////////

    task automatic load_weights(int taps);
        for (int t = 0; t < taps; t++) begin
            weight_valid = 1'b1;
            weight_data  = weight_t'(wgt_vals[t]);
            @(negedge clk_core);
        end
        weight_valid = 1'b0;
    endtask

    task automatic start_job(int r);
        check_protocol(job_accept == 1'b0, "job_accept high before job_start");
        job_num_taps    = tap_idx_t'(jobs[r].taps);
        job_num_outputs = out_cnt_t'(jobs[r].outs);
        job_relu        = jobs[r].relu;
        job_start       = 1'b1;
        @(negedge clk_core);
        check_protocol(job_accept == 1'b1, "job_accept missing one cycle after job_start");
        job_start = 1'b0;
        @(negedge clk_core);
        check_protocol(job_accept == 1'b0, "job_accept high for more than one cycle");
    endtask

    task automatic drive_pixels(int r);
        int quota;
        int gaps;
        quota = jobs[r].taps * jobs[r].outs;
        for (int k = 0; k < quota; k++) begin
            if (jobs[r].gap_mode != 0) begin
                gaps = take_bits(2);
                repeat (gaps) @(negedge clk_core);
            end
            // Stay within the buffer depth as counted by finished outputs
            while (k - res_seen * jobs[r].taps >= BUF_DEPTH) begin
                @(negedge clk_core);
            end
            pixel_valid = 1'b1;
            pixel_data  = pixel_t'(pix_vals[k]);
            // Stray start while the job is active
            if (k == 0) begin
                job_start = 1'b1;
            end
            @(negedge clk_core);
            if (k == 0) begin
                check_protocol(job_accept == 1'b0, "job_start accepted while active");
                job_start = 1'b0;
            end
            pixel_valid = 1'b0;
        end
        // Surplus pixels past the quota
        if (jobs[r].gap_mode == 2) begin
            repeat (3) begin
                pixel_valid = 1'b1;
                pixel_data  = pixel_t'(rand_byte());
                @(negedge clk_core);
            end
            pixel_valid = 1'b0;
        end
    endtask

    task automatic collect_results(int r);
        for (int j = 0; j < jobs[r].n_exp; j++) begin
            while (result_valid !== 1'b1) begin
                @(negedge clk_core);
            end
            check_value(int'(result_data), exp_vals[j], $sformatf("job %0d result %0d", r, j));
            check_protocol(job_complete == 1'b0, "job_complete high before the last result");
            res_seen++;
            @(negedge clk_core);
        end
        check_protocol(job_complete == 1'b1, "job_complete not one cycle after last result");
    endtask

    task automatic finish_job();
        // Stray start while complete and a late acknowledge
        job_start = 1'b1;
        repeat (3) begin
            @(negedge clk_core);
            job_start = 1'b0;
            check_protocol(job_accept == 1'b0, "job_start accepted while complete");
            check_protocol(job_complete == 1'b1, "job_complete dropped before acknowledge");
            check_protocol(result_valid == 1'b0, "result_valid after the last result");
        end
        job_complete_ack = 1'b1;
        @(negedge clk_core);
        job_complete_ack = 1'b0;
        check_protocol(job_complete == 1'b0, "job_complete still high after acknowledge");
    endtask

    task automatic run_job(int r);
        pix_vals.delete();
        exp_vals.delete();
        res_seen = 0;
        for (int t = 0; t < jobs[r].taps; t++) begin
            wgt_vals[t] = rand_byte();
        end
        for (int k = 0; k < jobs[r].taps * jobs[r].outs; k++) begin
            pix_vals.push_back(rand_byte());
        end
        for (int j = 0; j < jobs[r].outs; j++) begin
            exp_vals.push_back(ref_output(jobs[r].taps, j, jobs[r].relu));
        end
        load_weights(jobs[r].taps);
        start_job(r);
        fork
            drive_pixels(r);
            collect_results(r);
        join
        finish_job();
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int limit;
        rst              = 1'b1;
        job_start        = 1'b0;
        job_num_taps     = '0;
        job_num_outputs  = '0;
        job_relu         = 1'b0;
        job_complete_ack = 1'b0;
        weight_valid     = 1'b0;
        weight_data      = '0;
        pixel_valid      = 1'b0;
        pixel_data       = '0;
        lfsr_state       = 16'd8749;

        // taps, outputs, relu, gap mode (0 none, 1 gaps, 2 gaps and surplus), results
        jobs[0] = '{9, 4, 1'b0, 0, 4};
        jobs[1] = '{9, 5, 1'b1, 0, 5};
        jobs[2] = '{3, 8, 1'b0, 1, 8};
        jobs[3] = '{1, 10, 1'b1, 2, 10};
        jobs[4] = '{9, 3, 1'b0, 2, 3};
        jobs[5] = '{5, 6, 1'b1, 1, 6};

        limit = 0;
        for (int r = 0; r < NUM_JOBS; r++) begin
            limit = limit + jobs[r].taps * jobs[r].outs * 4;
        end
        limit = (limit + 200) * 20;
        fork
            begin
                #(limit);
                $display("Watchdog expired after %0d ns with the test still running", limit);
                $display("Done: errors found");
                $finish;
            end
        join_none

        repeat (8) @(negedge clk_core);
        rst = 1'b0;

        // Quiet outputs with no job started
        repeat (5) begin
            @(negedge clk_core);
            check_protocol(job_accept == 1'b0, "job_accept high after reset");
            check_protocol(job_complete == 1'b0, "job_complete high after reset");
            check_protocol(result_valid == 1'b0, "result_valid high after reset");
        end

        for (int r = 0; r < NUM_JOBS; r++) begin
            run_job(r);
        end
        repeat (2) @(negedge clk_core);

        $display("Checks finished: %0d value errors, %0d protocol errors",
                 value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hdl/conv_quad_pkg.sv
hdl/pixel_buf_if.sv
hdl/pixel_loader.sv
hdl/prefetch_buffer.sv
hdl/weight_table.sv
hdl/mac_engine.sv
hdl/conv_quad_top.sv
tb/conv_quad_tb.sv

// File: Makefile
# Verilator flow for the convolution engine

TOP = conv_quad_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "^Done: no errors" sim.log; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
